//--- run.sh
#!/usr/bin/env bash
# build and run the warp scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
    --top-module tb_warp_scheduler \
    -f warp_scheduler.f \
    --Mdir obj_dir -o sim_tb_warp_scheduler
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb_warp_scheduler)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1

//--- sched_cfg_pkg.sv
// scheduler size constants for warps, threads, PCs and counters
`default_nettype none

package sched_cfg_pkg;

    // warps held by the scheduler
    localparam int num_warps = 4;

    // threads per warp, one mask bit each
    localparam int num_threads = 4;

    // bits of a warp id, log2 of num_warps
    localparam int nw_width = 2;

    // word address width, byte offset dropped
    localparam int pc_bits = 30;

    // busy-cycle and retired-instruction counters
    localparam int ctr_bits = 32;

    // per-cycle commit count, holds 0 to num_warps
    localparam int commit_width = 3;

endpackage

`default_nettype wire

//--- sched_counters.sv
// sched_counters module, busy flag, busy-cycle counter and retired-instruction counter
`default_nettype none

module sched_counters (
    input  logic                       clk,
    input  logic                       reset,
    input  sched_msg_pkg::warp_vec_t   active_warps,
    input  sched_msg_pkg::commit_cnt_t commit_cnt,
    output logic                       busy,
    output sched_msg_pkg::ctr_t        cycles,
    output sched_msg_pkg::ctr_t        instret
);
    import sched_cfg_pkg::*;
    import sched_msg_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            cycles  <= '0;
            instret <= '0;
        end else begin
            // busy lags the active set by one cycle
            busy <= (active_warps != '0);
            if (busy) begin
                cycles <= cycles + ctr_t'(1);
            end
            instret <= instret + {{(ctr_bits - commit_width){1'b0}}, commit_cnt};
        end
    end

endmodule

`default_nettype wire

//--- sched_msg_pkg.sv
// scheduler data types for warp ids, thread masks, PCs and counters
`default_nettype none

package sched_msg_pkg;

    // warp index
    typedef logic [sched_cfg_pkg::nw_width-1:0] wid_t;

    // bit i set means thread i runs
    typedef logic [sched_cfg_pkg::num_threads-1:0] tmask_t;

    // word address
    typedef logic [sched_cfg_pkg::pc_bits-1:0] pc_t;

    // one flag per warp
    typedef logic [sched_cfg_pkg::num_warps-1:0] warp_vec_t;

    // counter value
    typedef logic [sched_cfg_pkg::ctr_bits-1:0] ctr_t;

    // retired instructions in one cycle
    typedef logic [sched_cfg_pkg::commit_width-1:0] commit_cnt_t;

endpackage

`default_nettype wire

//--- sched_out_buf.sv
// sched_out_buf module, two-entry registered output buffer with valid/ready
`default_nettype none

module sched_out_buf (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  sched_msg_pkg::wid_t   in_wid,
    input  sched_msg_pkg::tmask_t in_tmask,
    input  sched_msg_pkg::pc_t    in_pc,
    output logic                  out_valid,
    input  logic                  out_ready,
    output sched_msg_pkg::wid_t   out_wid,
    output sched_msg_pkg::tmask_t out_tmask,
    output sched_msg_pkg::pc_t    out_pc
);
    import sched_cfg_pkg::*;
    import sched_msg_pkg::*;

    typedef logic [nw_width+num_threads+pc_bits-1:0] entry_t;

    entry_t main_q;
    entry_t skid_q;
    logic   skid_valid;
    logic   push;
    logic   pop;

    // skid is only filled while main is held, so a full skid means two entries
    assign in_ready = ~skid_valid;
    assign push     = in_valid && in_ready;
    assign pop      = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (skid_valid) begin
            if (pop) begin
                skid_valid <= 1'b0;
            end
        end else if (push) begin
            if (!out_valid || pop) begin
                out_valid <= 1'b1;
            end else begin
                skid_valid <= 1'b1;
            end
        end else if (pop) begin
            out_valid <= 1'b0;
        end
    end

    // payload moves without reset
    always_ff @(posedge clk) begin
        if (skid_valid) begin
            if (pop) begin
                main_q <= skid_q;
            end
        end else if (push) begin
            if (!out_valid || pop) begin
                main_q <= {in_wid, in_tmask, in_pc};
            end else begin
                skid_q <= {in_wid, in_tmask, in_pc};
            end
        end
    end

    assign {out_wid, out_tmask, out_pc} = main_q;

endmodule

`default_nettype wire

//--- tb_warp_scheduler.sv
// tb_warp_scheduler testbench with random stimulus, reference model, checks and watchdog
`default_nettype none

module tb_warp_scheduler;
    timeunit 1ns;
    timeprecision 1ps;

    import sched_cfg_pkg::*;
    import sched_msg_pkg::*;

    typedef struct packed {
        wid_t   wid;
        tmask_t tmask;
        pc_t    pc;
    } item_t;

    localparam int num_cycles    = 3000;
    localparam int reset_cycles  = 3;
    localparam int margin_cycles = 200;
    localparam int clk_period    = 4;
    localparam pc_t start_pc     = 30'h0000_1000;

    logic        clk = 1'b0;
    logic        reset;
    pc_t         startup_pc;
    logic        tmc_valid;
    wid_t        tmc_wid;
    tmask_t      tmc_mask;
    logic        branch_valid;
    wid_t        branch_wid;
    logic        branch_taken;
    pc_t         branch_dest;
    logic        unlock_valid;
    wid_t        unlock_wid;
    commit_cnt_t commit_cnt;
    logic        sched_ready;
    logic        sched_valid;
    wid_t        sched_wid;
    tmask_t      sched_tmask;
    pc_t         sched_pc;
    logic        busy;
    ctr_t        cycles;
    ctr_t        instret;

    // model state as of the last rising edge
    warp_vec_t   m_active;
    warp_vec_t   m_stalled;
    pc_t         m_pcs [num_warps];
    tmask_t      m_masks [num_warps];
    int          m_count;
    logic        m_busy;
    ctr_t        m_cycles;
    ctr_t        m_instret;
    item_t       exp_q [$];

    logic [31:0] lfsr_state = 32'hf313_40bf;
    int          value_errors = 0;
    int          seq_errors = 0;
    int          transfers = 0;
    logic        held = 1'b0;
    item_t       held_item;
    item_t       exp_item;

    always #2 clk = ~clk;

    warp_scheduler UUT (
        .clk          (clk),
        .reset        (reset),
        .startup_pc   (startup_pc),
        .tmc_valid    (tmc_valid),
        .tmc_wid      (tmc_wid),
        .tmc_mask     (tmc_mask),
        .branch_valid (branch_valid),
        .branch_wid   (branch_wid),
        .branch_taken (branch_taken),
        .branch_dest  (branch_dest),
        .unlock_valid (unlock_valid),
        .unlock_wid   (unlock_wid),
        .commit_cnt   (commit_cnt),
        .sched_ready  (sched_ready),
        .sched_valid  (sched_valid),
        .sched_wid    (sched_wid),
        .sched_tmask  (sched_tmask),
        .sched_pc     (sched_pc),
        .busy         (busy),
        .cycles       (cycles),
        .instret      (instret)
    );

    // right-shift galois lfsr stepped once per bit
    function automatic logic next_random_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'ha300_0000;
        end
        return out;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_random_bit()};
        end
        return v;
    endfunction

    function automatic void model_reset();
        m_active  = warp_vec_t'(1);
        m_stalled = '0;
        for (int i = 0; i < num_warps; i++) begin
            m_pcs[i]   = '0;
            m_masks[i] = '0;
        end
        m_pcs[0]   = start_pc;
        m_masks[0] = tmask_t'(1);
        m_count    = 0;
        m_busy     = 1'b0;
        m_cycles   = '0;
        m_instret  = '0;
    endfunction

    // one rising edge of the scheduler with the inputs just driven
    function automatic void model_step();
        warp_vec_t ready;
        logic      found;
        logic      fire;
        logic      pop;
        wid_t      pick;
        pc_t       pick_pc;
        ready = m_active & ~m_stalled;
        found = 1'b0;
        pick  = '0;
        for (int i = 0; i < num_warps; i++) begin
            if (!found && ready[i]) begin
                found = 1'b1;
                pick  = wid_t'(i);
            end
        end
        pick_pc = m_pcs[pick];
        fire    = found && (m_count < 2);
        pop     = (m_count > 0) && sched_ready;
        if (fire) begin
            exp_q.push_back(item_t'{wid: pick, tmask: m_masks[pick], pc: pick_pc});
        end
        m_count   = m_count + int'(fire) - int'(pop);
        m_cycles  = m_cycles + ctr_t'(m_busy);
        m_instret = m_instret + ctr_t'(commit_cnt);
        m_busy    = (m_active != '0);
        if (unlock_valid) begin
            m_stalled[unlock_wid] = 1'b0;
        end
        if (tmc_valid) begin
            m_masks[tmc_wid]   = tmc_mask;
            m_active[tmc_wid]  = (tmc_mask != '0);
            m_stalled[tmc_wid] = 1'b0;
        end
        if (branch_valid) begin
            m_stalled[branch_wid] = 1'b0;
            if (branch_taken) begin
                m_pcs[branch_wid] = branch_dest;
            end
        end
        if (fire) begin
            m_stalled[pick] = 1'b1;
            m_pcs[pick]     = pick_pc + pc_t'(1);
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error %s got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_state();
        check_value("busy", 32'(busy), 32'(m_busy));
        check_value("cycles", cycles, m_cycles);
        check_value("instret", instret, m_instret);
        check_value("sched_valid", 32'(sched_valid), 32'(m_count > 0));
    endtask

    task automatic drive_random();
        sched_ready  = (random_bits(2) != 0);
        tmc_valid    = (random_bits(3) == 0);
        tmc_wid      = wid_t'(random_bits(nw_width));
        tmc_mask     = tmask_t'(random_bits(num_threads));
        branch_valid = (random_bits(2) == 0);
        branch_wid   = wid_t'(random_bits(nw_width));
        branch_taken = random_bits(1) != 0;
        branch_dest  = pc_t'(random_bits(pc_bits));
        unlock_valid = (random_bits(2) == 0);
        unlock_wid   = wid_t'(random_bits(nw_width));
        // full range 0 to num_warps
        commit_cnt   = commit_cnt_t'(random_bits(commit_width) % (num_warps + 1));
    endtask

    task automatic drive_idle(input logic ready);
        sched_ready  = ready;
        tmc_valid    = 1'b0;
        tmc_wid      = '0;
        tmc_mask     = '0;
        branch_valid = 1'b0;
        branch_wid   = '0;
        branch_taken = 1'b0;
        branch_dest  = '0;
        unlock_valid = 1'b0;
        unlock_wid   = '0;
        commit_cnt   = '0;
    endtask

    task automatic print_counts();
        $display("value errors %0d, sequence errors %0d, transfers %0d",
                 value_errors, seq_errors, transfers);
    endtask

    // each transfer takes the oldest predicted item
    always @(posedge clk) begin
        if (!reset) begin
            if (held) begin
                assert (sched_valid && {sched_wid, sched_tmask, sched_pc} == held_item) else begin
                    $display("scheduler output changed while fetch was not ready");
                    seq_errors++;
                end
            end
            if (sched_valid && sched_ready) begin
                assert (exp_q.size() != 0) else begin
                    $display("transfer seen with no item predicted by the model");
                    seq_errors++;
                end
                if (exp_q.size() != 0) begin
                    exp_item = exp_q.pop_front();
                    check_value("sched_wid", 32'(sched_wid), 32'(exp_item.wid));
                    check_value("sched_tmask", 32'(sched_tmask), 32'(exp_item.tmask));
                    check_value("sched_pc", 32'(sched_pc), 32'(exp_item.pc));
                end
                transfers++;
            end
            held      = sched_valid && !sched_ready;
            held_item = item_t'{wid: sched_wid, tmask: sched_tmask, pc: sched_pc};
        end
    end

    initial begin
        reset      = 1'b1;
        startup_pc = start_pc;
        drive_idle(1'b0);
        model_reset();
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int n = 0; n < num_cycles; n++) begin
            check_state();
            drive_random();
            model_step();
            @(negedge clk);
        end
        // drain with fetch always ready and no releases
        while (exp_q.size() != 0) begin
            check_state();
            drive_idle(1'b1);
            model_step();
            @(negedge clk);
        end
        check_state();
        assert (transfers > 0) else begin
            $display("no item was ever transferred");
            seq_errors++;
        end
        print_counts();
        if (value_errors == 0 && seq_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // watchdog sized from the random phase plus drain margin
    initial begin
        #((num_cycles + reset_cycles + margin_cycles) * clk_period);
        $display("timeout, the output queue did not drain in time");
        print_counts();
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- warp_scheduler.f
sched_cfg_pkg.sv
sched_msg_pkg.sv
warp_state.sv
warp_table.sv
warp_select.sv
sched_out_buf.sv
sched_counters.sv
warp_scheduler.sv
tb_warp_scheduler.sv

//--- warp_scheduler.sv
// warp_scheduler top module, connects warp state, table, select, output buffer and counters
`default_nettype none

module warp_scheduler (
    input  logic                       clk,
    input  logic                       reset,
    input  sched_msg_pkg::pc_t         startup_pc,
    input  logic                       tmc_valid,
    input  sched_msg_pkg::wid_t        tmc_wid,
    input  sched_msg_pkg::tmask_t      tmc_mask,
    input  logic                       branch_valid,
    input  sched_msg_pkg::wid_t        branch_wid,
    input  logic                       branch_taken,
    input  sched_msg_pkg::pc_t         branch_dest,
    input  logic                       unlock_valid,
    input  sched_msg_pkg::wid_t        unlock_wid,
    input  sched_msg_pkg::commit_cnt_t commit_cnt,
    input  logic                       sched_ready,
    output logic                       sched_valid,
    output sched_msg_pkg::wid_t        sched_wid,
    output sched_msg_pkg::tmask_t      sched_tmask,
    output sched_msg_pkg::pc_t         sched_pc,
    output logic                       busy,
    output sched_msg_pkg::ctr_t        cycles,
    output sched_msg_pkg::ctr_t        instret
);
    import sched_cfg_pkg::*;
    import sched_msg_pkg::*;

    warp_vec_t active_warps;
    warp_vec_t stalled_warps;
    pc_t       warp_pcs [num_warps];
    tmask_t    thread_masks [num_warps];
    logic      pick_valid;
    wid_t      pick_wid;
    tmask_t    pick_tmask;
    pc_t       pick_pc;
    logic      buf_in_ready;
    logic      pick_fire;

    // a pick only counts once the buffer takes it
    assign pick_fire = pick_valid && buf_in_ready;

    warp_state u_state (
        .clk           (clk),
        .reset         (reset),
        .tmc_valid     (tmc_valid),
        .tmc_wid       (tmc_wid),
        .tmc_mask      (tmc_mask),
        .branch_valid  (branch_valid),
        .branch_wid    (branch_wid),
        .unlock_valid  (unlock_valid),
        .unlock_wid    (unlock_wid),
        .pick_fire     (pick_fire),
        .pick_wid      (pick_wid),
        .active_warps  (active_warps),
        .stalled_warps (stalled_warps)
    );

    warp_table u_table (
        .clk          (clk),
        .reset        (reset),
        .startup_pc   (startup_pc),
        .tmc_valid    (tmc_valid),
        .tmc_wid      (tmc_wid),
        .tmc_mask     (tmc_mask),
        .branch_valid (branch_valid),
        .branch_taken (branch_taken),
        .branch_wid   (branch_wid),
        .branch_dest  (branch_dest),
        .pick_fire    (pick_fire),
        .pick_wid     (pick_wid),
        .pick_pc      (pick_pc),
        .warp_pcs     (warp_pcs),
        .thread_masks (thread_masks)
    );

    warp_select u_select (
        .active_warps  (active_warps),
        .stalled_warps (stalled_warps),
        .warp_pcs      (warp_pcs),
        .thread_masks  (thread_masks),
        .pick_valid    (pick_valid),
        .pick_wid      (pick_wid),
        .pick_tmask    (pick_tmask),
        .pick_pc       (pick_pc)
    );

    sched_out_buf u_out_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (pick_valid),
        .in_ready  (buf_in_ready),
        .in_wid    (pick_wid),
        .in_tmask  (pick_tmask),
        .in_pc     (pick_pc),
        .out_valid (sched_valid),
        .out_ready (sched_ready),
        .out_wid   (sched_wid),
        .out_tmask (sched_tmask),
        .out_pc    (sched_pc)
    );

    sched_counters u_counters (
        .clk          (clk),
        .reset        (reset),
        .active_warps (active_warps),
        .commit_cnt   (commit_cnt),
        .busy         (busy),
        .cycles       (cycles),
        .instret      (instret)
    );

endmodule

`default_nettype wire

//--- warp_select.sv
// warp_select module, lowest-index ready warp pick with mask and PC readout
`default_nettype none

module warp_select (
    input  sched_msg_pkg::warp_vec_t active_warps,
    input  sched_msg_pkg::warp_vec_t stalled_warps,
    input  sched_msg_pkg::pc_t       warp_pcs [sched_cfg_pkg::num_warps],
    input  sched_msg_pkg::tmask_t    thread_masks [sched_cfg_pkg::num_warps],
    output logic                     pick_valid,
    output sched_msg_pkg::wid_t      pick_wid,
    output sched_msg_pkg::tmask_t    pick_tmask,
    output sched_msg_pkg::pc_t       pick_pc
);
    import sched_cfg_pkg::*;
    import sched_msg_pkg::*;

    warp_vec_t ready_warps;

    assign ready_warps = active_warps & ~stalled_warps;

    // scan downwards so the lowest ready index is the last one written
    always_comb begin
        pick_valid = 1'b0;
        pick_wid   = '0;
        for (int i = num_warps - 1; i >= 0; i--) begin
            if (ready_warps[i]) begin
                pick_valid = 1'b1;
                pick_wid   = wid_t'(i);
            end
        end
    end

    assign pick_tmask = thread_masks[pick_wid];
    assign pick_pc    = warp_pcs[pick_wid];

endmodule

`default_nettype wire

//--- warp_state.sv
// warp_state module, per-warp active and stalled tracking with release and stall rules
`default_nettype none

module warp_state (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     tmc_valid,
    input  sched_msg_pkg::wid_t      tmc_wid,
    input  sched_msg_pkg::tmask_t    tmc_mask,
    input  logic                     branch_valid,
    input  sched_msg_pkg::wid_t      branch_wid,
    input  logic                     unlock_valid,
    input  sched_msg_pkg::wid_t      unlock_wid,
    input  logic                     pick_fire,
    input  sched_msg_pkg::wid_t      pick_wid,
    output sched_msg_pkg::warp_vec_t active_warps,
    output sched_msg_pkg::warp_vec_t stalled_warps
);
    import sched_cfg_pkg::*;
    import sched_msg_pkg::*;

    warp_vec_t active_n;
    warp_vec_t stalled_n;

    // releases first, then the pick stall so it wins on a clash
    always_comb begin
        active_n  = active_warps;
        stalled_n = stalled_warps;
        for (int i = 0; i < num_warps; i++) begin
            if (unlock_valid && unlock_wid == wid_t'(i)) begin
                stalled_n[i] = 1'b0;
            end
            if (tmc_valid && tmc_wid == wid_t'(i)) begin
                // zero mask retires the warp
                active_n[i]  = (tmc_mask != '0);
                stalled_n[i] = 1'b0;
            end
            if (branch_valid && branch_wid == wid_t'(i)) begin
                stalled_n[i] = 1'b0;
            end
            if (pick_fire && pick_wid == wid_t'(i)) begin
                stalled_n[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // only warp 0 runs out of reset
            active_warps  <= warp_vec_t'(1);
            stalled_warps <= '0;
        end else begin
            active_warps  <= active_n;
            stalled_warps <= stalled_n;
        end
    end

endmodule

`default_nettype wire

//--- warp_table.sv
// warp_table module, per-warp PC and thread mask storage
`default_nettype none

module warp_table (
    input  logic                  clk,
    input  logic                  reset,
    input  sched_msg_pkg::pc_t    startup_pc,
    input  logic                  tmc_valid,
    input  sched_msg_pkg::wid_t   tmc_wid,
    input  sched_msg_pkg::tmask_t tmc_mask,
    input  logic                  branch_valid,
    input  logic                  branch_taken,
    input  sched_msg_pkg::wid_t   branch_wid,
    input  sched_msg_pkg::pc_t    branch_dest,
    input  logic                  pick_fire,
    input  sched_msg_pkg::wid_t   pick_wid,
    input  sched_msg_pkg::pc_t    pick_pc,
    output sched_msg_pkg::pc_t    warp_pcs [sched_cfg_pkg::num_warps],
    output sched_msg_pkg::tmask_t thread_masks [sched_cfg_pkg::num_warps]
);
    import sched_cfg_pkg::*;
    import sched_msg_pkg::*;

    pc_t    pcs_n [num_warps];
    tmask_t masks_n [num_warps];

    always_comb begin
        pcs_n   = warp_pcs;
        masks_n = thread_masks;
        if (tmc_valid) begin
            masks_n[tmc_wid] = tmc_mask;
        end
        if (branch_valid && branch_taken) begin
            pcs_n[branch_wid] = branch_dest;
        end
        // advance after the branch load, so it takes precedence
        if (pick_fire) begin
            pcs_n[pick_wid] = pick_pc + pc_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_warps; i++) begin
                warp_pcs[i]     <= '0;
                thread_masks[i] <= '0;
            end
            // warp 0 starts with thread 0 at the boot address
            warp_pcs[0]     <= startup_pc;
            thread_masks[0] <= tmask_t'(1);
        end else begin
            warp_pcs     <= pcs_n;
            thread_masks <= masks_n;
        end
    end

endmodule

`default_nettype wire
